/* sim.f */
rtl/rv32i_isa_pkg.sv
rtl/mem_stage_pkg.sv
rtl/exec_latch.sv
rtl/data_memory_access.sv
rtl/stage4_memory_operation.sv
rtl/writeback_stage.sv
rtl/mem_stage_top.sv
verification/mem_stage_assertions.sv
verification/mem_stage_tb.sv

/* Makefile */
# Verilator build and run of the memory stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_stage_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ns

module mem_stage_tb;

	import rv32i_isa_pkg::*;
	import mem_stage_pkg::*;

	localparam int RANDOM_COUNT = 2000;
	// reset, fill, directed sections, random mix and a margin
	localparam int MAX_CYCLES   = 10 + 64 + 300 + RANDOM_COUNT + 200;
	// non-memory classes first, load and store last
	localparam encoding_t CLASSES [9] = '{ENCODING_LUI, ENCODING_AUIPC, ENCODING_JAL,
		ENCODING_JALR, ENCODING_ARITH_IMM, ENCODING_ARITH_REG, ENCODING_BRANCH,
		ENCODING_LOAD, ENCODING_STORE};
	localparam func3_t LOAD_CODES [5] = '{FUNC3_LOAD_BYTE, FUNC3_LOAD_HWORD,
		FUNC3_LOAD_WORD, FUNC3_LOAD_UBYTE, FUNC3_LOAD_UHWORD};

	logic         clk_i = 1'b0;
	logic         rst_n_i = 1'b0;
	exec_bundle_t ex_bundle_i = '0;
	wb_bundle_t   wb_o;
	// byte image of the data memory
	logic [7:0]   mem_model [256];
	// expected outputs of the requests in flight
	wb_bundle_t   exp_q [$];
	string        test_name = "reset";

	mem_stage_top #(
		.DEPTH_WORDS (64)
	) dut0 (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.ex_bundle_i (ex_bundle_i),
		.wb_o        (wb_o)
	);

	bind mem_stage_top mem_stage_assertions asserts0 (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.wb_i    (wb_o)
	);

	always #50 clk_i = ~clk_i;

	function automatic exec_bundle_t instr(encoding_t enc, func3_t f3, reg_idx_t fd,
		word_t res, word_t sd);
		return '{valid: 1'b1, encoding: enc, func3: f3, fdest: fd, result: res, store_data: sd};
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	task automatic model(input exec_bundle_t b, output wb_bundle_t e);
		logic [7:0] a;
		logic [7:0] ba;
		word_t      raw;
		logic       mis;
		logic       is_ld;
		logic       is_st;
		int         nbytes;
		e      = '0;
		raw    = '0;
		a      = b.result[7:0];
		is_ld  = (b.encoding == ENCODING_LOAD);
		is_st  = (b.encoding == ENCODING_STORE);
		// halfword needs an even address, word a 4-byte boundary
		mis    = 1'b0;
		if ((is_ld && (b.func3 == FUNC3_LOAD_HWORD || b.func3 == FUNC3_LOAD_UHWORD)) ||
			(is_st && b.func3 == FUNC3_STORE_HWORD))
			mis = a[0];
		if ((is_ld || is_st) && b.func3 == FUNC3_LOAD_WORD)
			mis = (a[1:0] != 2'b00);
		nbytes = (b.func3 == 3'd0) ? 1 : (b.func3 == 3'd1) ? 2 : (b.func3 == 3'd2) ? 4 : 0;
		// bytes from the addressed one up to the end of the word
		for (int j = 0; j < 4 - int'(a[1:0]); j++) begin
			ba = a + 8'(j);
			raw[8*j +: 8] = mem_model[ba];
		end
		if (!b.valid) begin
			e = '0;
		end else if (mis) begin
			e.exception = 1'b1;
		end else begin
			// stores update the image in program order
			for (int j = 0; j < nbytes && is_st; j++) begin
				ba = a + 8'(j);
				mem_model[ba] = b.store_data[8*j +: 8];
			end
			if (b.fdest != 5'd0) begin
				case (b.encoding)
					ENCODING_LOAD: begin
						e.writeback_flag = 1'b1;
						case (b.func3)
							3'd0: e.writeback_value = {{24{raw[7]}}, raw[7:0]};
							3'd1: e.writeback_value = {{16{raw[15]}}, raw[15:0]};
							3'd2: e.writeback_value = raw;
							3'd4: e.writeback_value = {24'd0, raw[7:0]};
							3'd5: e.writeback_value = {16'd0, raw[15:0]};
							default: begin
								e.writeback_flag = 1'b0;
								e.exception      = 1'b1;
							end
						endcase
					end
					ENCODING_BRANCH, ENCODING_STORE: e = '0;
					default: begin
						e.writeback_flag  = 1'b1;
						e.writeback_value = b.result;
					end
				endcase
				if (e.writeback_flag)
					e.fdest = b.fdest;
			end
		end
	endtask

	// one cycle: check the output of three drives back, then drive
	task automatic step(input exec_bundle_t b);
		wb_bundle_t exp_now;
		wb_bundle_t exp_new;
		@(negedge clk_i);
		exp_now = '0;
		if (exp_q.size() == 3)
			exp_now = exp_q.pop_front();
		assert (wb_o === exp_now) else begin
			$display("MISMATCH %s expected %h actual %h", test_name, exp_now, wb_o);
			$display("Test FAILED");
			$fatal(1);
		end
		model(b, exp_new);
		exp_q.push_back(exp_new);
		ex_bundle_i = b;
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		exec_bundle_t b;
		int           k;
		void'($urandom(32'h05e2_b425));
		// live requests during reset, none of them may reach the output
		repeat (9) begin
			@(negedge clk_i);
			ex_bundle_i = instr(CLASSES[$urandom_range(5, 0)], func3_t'($urandom),
				reg_idx_t'($urandom_range(31, 1)), word_t'($urandom), word_t'($urandom));
		end
		@(negedge clk_i);
		ex_bundle_i = '0;
		rst_n_i = 1'b1;

		// every word written, pattern built from the full address
		test_name = "fill";
		for (int w = 0; w < 64; w++)
			step(instr(ENCODING_STORE, FUNC3_STORE_WORD, 5'd0, word_t'(w * 4),
				(word_t'(w * 4) * 32'h0101_0101) ^ 32'h5a3c_96e1));

		test_name = "non_memory";
		for (int c = 0; c < 7; c++)
			step(instr(CLASSES[c], func3_t'($urandom), reg_idx_t'($urandom_range(31, 1)),
				word_t'($urandom), word_t'($urandom)));

		// each store size and offset, then every load form at every offset
		test_name = "load_store";
		for (int s = 0; s < 3; s++) begin
			for (int off = 0; off < 4; off += (1 << s)) begin
				step(instr(ENCODING_STORE, func3_t'(s), reg_idx_t'($urandom),
					word_t'(32'h40 + 16 * s + off), word_t'($urandom)));
				for (int f = 0; f < 5; f++)
					for (int o = 0; o < 4; o++)
						step(instr(ENCODING_LOAD, LOAD_CODES[f], reg_idx_t'($urandom_range(31, 1)),
							word_t'(32'h40 + 16 * s + o), '0));
			end
		end

		test_name = "bad_func3";
		step(instr(ENCODING_LOAD, 3'd3, 5'd7, word_t'($urandom_range(255, 0)), '0));
		step(instr(ENCODING_LOAD, 3'd6, 5'd8, word_t'($urandom_range(255, 0)), '0));
		step(instr(ENCODING_LOAD, 3'd7, 5'd9, word_t'($urandom_range(255, 0)), '0));

		// faulting stores must leave the word untouched
		test_name = "misaligned";
		for (int o = 1; o < 4; o++)
			step(instr(ENCODING_STORE, FUNC3_STORE_WORD, 5'd3, word_t'(32'h80 + o), '1));
		step(instr(ENCODING_STORE, FUNC3_STORE_HWORD, 5'd3, word_t'(32'h81), '1));
		step(instr(ENCODING_STORE, FUNC3_STORE_HWORD, 5'd3, word_t'(32'h83), '1));
		step(instr(ENCODING_LOAD, FUNC3_LOAD_WORD, 5'd4, word_t'(32'h80), '0));
		for (int o = 1; o < 4; o++)
			step(instr(ENCODING_LOAD, FUNC3_LOAD_WORD, 5'd4, word_t'(32'h80 + o), '0));
		step(instr(ENCODING_LOAD, FUNC3_LOAD_HWORD, 5'd5, word_t'(32'h81), '0));
		step(instr(ENCODING_LOAD, FUNC3_LOAD_UHWORD, 5'd5, word_t'(32'h83), '0));

		test_name = "zero_dest";
		for (int c = 0; c < 9; c++)
			step(instr(CLASSES[c], FUNC3_LOAD_WORD, 5'd0, word_t'(32'h10), word_t'($urandom)));
		repeat (4) step('0);

		test_name = "random";
		repeat (RANDOM_COUNT) begin
			k = $urandom_range(8, 0);
			b = instr(CLASSES[k], func3_t'($urandom), reg_idx_t'($urandom),
				word_t'($urandom_range(255, 0)), word_t'($urandom));
			// only loads and stores need an in-range address
			if (k < 7)
				b.result = word_t'($urandom);
			b.valid = ($urandom_range(9, 0) != 0);
			step(b);
		end

		// drain the pipeline
		test_name = "drain";
		repeat (3) step('0);

		if (dut0.asserts0.failed) begin
			$display("Test FAILED");
			$fatal(1);
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	// a failing concurrent property ends the run right away
	initial begin
		wait (dut0.asserts0.failed);
		$display("Test FAILED");
		$fatal(1);
	end

	// watchdog
	initial begin
		repeat (MAX_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, the run did not finish", MAX_CYCLES);
		$display("Test FAILED");
		$fatal(1);
	end

endmodule

/* verification/mem_stage_assertions.sv */
`timescale 1ns/1ns

module mem_stage_assertions (
	input logic                      clk_i,
	input logic                      rst_n_i,
	input mem_stage_pkg::wb_bundle_t wb_i
);

	// raised by any failing property, the testbench reads it at the end
	logic failed = 1'b0;

	// ----------------------------------------
	// reset behavior
	// ----------------------------------------

	// output register cleared while reset is held
	reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> wb_i == '0)
		else begin
			$error("wb_o not cleared during reset");
			failed = 1'b1;
		end

	// pipeline still empty for the first cycles after release
	release_quiet: assert property (@(posedge clk_i)
		$rose(rst_n_i) |-> (wb_i == '0) ##1 (wb_i == '0) ##1 (wb_i == '0))
		else begin
			$error("wb_o not zero right after reset release");
			failed = 1'b1;
		end

	// ----------------------------------------
	// output consistency
	// ----------------------------------------

	// a faulting request never writes the register file
	flag_xor_exception: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(wb_i.exception && wb_i.writeback_flag))
		else begin
			$error("writeback_flag and exception high together");
			failed = 1'b1;
		end

	// r0 is never a write target
	no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.writeback_flag |-> wb_i.fdest != 5'd0)
		else begin
			$error("writeback_flag raised for register 0");
			failed = 1'b1;
		end

endmodule

/* rtl/mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top #(
	// data memory size in 32 bit words
	parameter int DEPTH_WORDS = 256
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  mem_stage_pkg::exec_bundle_t ex_bundle_i,
	output mem_stage_pkg::wb_bundle_t   wb_o
);

	import mem_stage_pkg::*;

	// ----------------------------------------
	// stage to stage wiring
	// ----------------------------------------

	// request latched from execute
	mem_bundle_t latch_bundle;
	// same request one cycle later, aligned with the read word
	mem_bundle_t access_bundle;
	// load word shifted to the addressed byte
	word_t       memory_data;

	// input side, lanes and alignment
	exec_latch latch0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.ex_bundle_i  (ex_bundle_i),
		.mem_bundle_o (latch_bundle)
	);

	// data array access
	data_memory_access #(
		.DEPTH_WORDS (DEPTH_WORDS)
	) access0 (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.mem_bundle_i  (latch_bundle),
		.mem_bundle_o  (access_bundle),
		.memory_data_o (memory_data)
	);

	// routing and output register
	writeback_stage wb0 (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.mem_bundle_i  (access_bundle),
		.memory_data_i (memory_data),
		.wb_o          (wb_o)
	);

endmodule

/* rtl/writeback_stage.sv */
`timescale 1ns/1ns

module writeback_stage (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  mem_stage_pkg::mem_bundle_t mem_bundle_i,
	input  mem_stage_pkg::word_t       memory_data_i,
	output mem_stage_pkg::wb_bundle_t  wb_o
);

	import mem_stage_pkg::*;

	logic       route_flag;
	word_t      route_value;
	logic       route_exception;
	wb_bundle_t wb_next;

	stage4_memory_operation router0 (
		.encoding_i        (mem_bundle_i.encoding),
		.func3_i           (mem_bundle_i.func3),
		.fdest_i           (mem_bundle_i.fdest),
		.memory_data_i     (memory_data_i),
		.stage3_result_i   (mem_bundle_i.result),
		.writeback_flag_o  (route_flag),
		.writeback_value_o (route_value),
		.exception_o       (route_exception)
	);

	// ----------------------------------------
	// merge with valid and alignment
	// ----------------------------------------
	always_comb begin
		// empty slot gives an all zero bundle
		wb_next = '0;
		if (mem_bundle_i.valid) begin
			if (mem_bundle_i.misaligned) begin
				// raised whatever the destination register is
				wb_next.exception = 1'b1;
			end else begin
				wb_next.exception = route_exception;
				// index and value only travel with a write
				if (route_flag) begin
					wb_next.writeback_flag  = 1'b1;
					wb_next.fdest           = mem_bundle_i.fdest;
					wb_next.writeback_value = route_value;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_o <= '0;
		end else begin
			wb_o <= wb_next;
		end
	end

endmodule

/* rtl/stage4_memory_operation.sv */
`timescale 1ns/1ns

module stage4_memory_operation (
	input  rv32i_isa_pkg::encoding_t encoding_i,
	input  rv32i_isa_pkg::func3_t    func3_i,
	input  mem_stage_pkg::reg_idx_t  fdest_i,
	// load word, already shifted to the addressed byte
	input  mem_stage_pkg::word_t     memory_data_i,
	// alu result from execute
	input  mem_stage_pkg::word_t     stage3_result_i,
	// high when the register file takes the value
	output logic                     writeback_flag_o,
	output mem_stage_pkg::word_t     writeback_value_o,
	// load with an unknown func3
	output logic                     exception_o
);

	import rv32i_isa_pkg::*;

	// ----------------------------------------
	// result routing
	// ----------------------------------------
	always_comb begin
		// defaults, nothing written
		writeback_flag_o  = 1'b0;
		writeback_value_o = '0;
		exception_o       = 1'b0;

		// r0 is hardwired, skip it entirely
		if (fdest_i != 5'd0) begin
			case (encoding_i)

				// arithmetic, upper immediates and jump links
				ENCODING_LUI, ENCODING_AUIPC, ENCODING_ARITH_IMM,
				ENCODING_ARITH_REG, ENCODING_JAL, ENCODING_JALR: begin
					writeback_flag_o  = 1'b1;
					writeback_value_o = stage3_result_i;
				end

				// load, size and sign taken from func3
				ENCODING_LOAD: begin
					writeback_flag_o = 1'b1;
					case (func3_i)
						FUNC3_LOAD_BYTE: begin
							writeback_value_o = {{24{memory_data_i[7]}}, memory_data_i[7:0]};
						end
						FUNC3_LOAD_HWORD: begin
							writeback_value_o = {{16{memory_data_i[15]}}, memory_data_i[15:0]};
						end
						FUNC3_LOAD_WORD: begin
							writeback_value_o = memory_data_i;
						end
						FUNC3_LOAD_UBYTE: begin
							writeback_value_o = {24'd0, memory_data_i[7:0]};
						end
						FUNC3_LOAD_UHWORD: begin
							writeback_value_o = {16'd0, memory_data_i[15:0]};
						end

						// codes 3, 6 and 7 are not defined
						default: begin
							writeback_flag_o = 1'b0;
							exception_o      = 1'b1;
						end
					endcase
				end

				// branch and store have no destination
				default: begin
					writeback_flag_o  = 1'b0;
					writeback_value_o = '0;
					exception_o       = 1'b0;
				end

			endcase
		end
	end

endmodule

/* rtl/data_memory_access.sv */
`timescale 1ns/1ns

module data_memory_access #(
	// power of two, the address wraps at this size
	parameter int DEPTH_WORDS = 256
) (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  mem_stage_pkg::mem_bundle_t mem_bundle_i,
	output mem_stage_pkg::mem_bundle_t mem_bundle_o,
	output mem_stage_pkg::word_t       memory_data_o
);

	import rv32i_isa_pkg::*;
	import mem_stage_pkg::*;

	localparam int IDX_W = $clog2(DEPTH_WORDS);

	word_t            mem_q [DEPTH_WORDS];
	word_t            rd_word_q;
	logic [IDX_W-1:0] word_idx;
	logic             wr_en;
	logic             rd_en;

	// word address, bits above the array size are dropped
	assign word_idx = mem_bundle_i.result[IDX_W+1:2];

	// misaligned stores never touch the array
	assign wr_en = mem_bundle_i.valid && !mem_bundle_i.misaligned;
	assign rd_en = mem_bundle_i.valid && (mem_bundle_i.encoding == ENCODING_LOAD);

	// ----------------------------------------
	// byte lane array
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < 4; i++) begin
			if (wr_en && mem_bundle_i.byte_en[i]) begin
				mem_q[word_idx][i*8 +: 8] <= mem_bundle_i.lane_data[i*8 +: 8];
			end
		end
		// old content is returned when a write hits the same edge
		if (rd_en) begin
			rd_word_q <= mem_q[word_idx];
		end
	end

	// ----------------------------------------
	// bundle follows the read data
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			mem_bundle_o.valid      <= 1'b0;
			mem_bundle_o.byte_en    <= '0;
			mem_bundle_o.misaligned <= 1'b0;
		end else begin
			mem_bundle_o.valid      <= mem_bundle_i.valid;
			mem_bundle_o.byte_en    <= mem_bundle_i.byte_en;
			mem_bundle_o.misaligned <= mem_bundle_i.misaligned;
		end
	end

	always_ff @(posedge clk_i) begin
		mem_bundle_o.encoding    <= mem_bundle_i.encoding;
		mem_bundle_o.func3       <= mem_bundle_i.func3;
		mem_bundle_o.fdest       <= mem_bundle_i.fdest;
		mem_bundle_o.result      <= mem_bundle_i.result;
		mem_bundle_o.lane_data   <= mem_bundle_i.lane_data;
		mem_bundle_o.byte_offset <= mem_bundle_i.byte_offset;
	end

	// addressed byte moved down to bit 0, extension happens in the router
	assign memory_data_o = rd_word_q >> {mem_bundle_o.byte_offset, 3'b000};

endmodule

/* rtl/exec_latch.sv */
`timescale 1ns/1ns

module exec_latch (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  mem_stage_pkg::exec_bundle_t ex_bundle_i,
	output mem_stage_pkg::mem_bundle_t  mem_bundle_o
);

	import rv32i_isa_pkg::*;
	import mem_stage_pkg::*;

	logic       is_load;
	logic       is_store;
	logic [1:0] addr_lo;
	byte_en_t   byte_en;
	word_t      lane_data;
	logic       misaligned;

	assign is_load  = (ex_bundle_i.encoding == ENCODING_LOAD);
	assign is_store = (ex_bundle_i.encoding == ENCODING_STORE);
	assign addr_lo  = ex_bundle_i.result[1:0];

	// ----------------------------------------
	// store lane steering
	// ----------------------------------------
	always_comb begin
		byte_en   = '0;
		lane_data = ex_bundle_i.store_data;
		if (is_store) begin
			case (ex_bundle_i.func3)
				FUNC3_STORE_BYTE: begin
					// same byte on every lane, enable picks one
					byte_en   = 4'b0001 << addr_lo;
					lane_data = {4{ex_bundle_i.store_data[7:0]}};
				end
				FUNC3_STORE_HWORD: begin
					byte_en   = 4'b0011 << {addr_lo[1], 1'b0};
					lane_data = {2{ex_bundle_i.store_data[15:0]}};
				end
				FUNC3_STORE_WORD: begin
					byte_en = 4'b1111;
				end
				// unknown store size writes nothing
				default: begin
					byte_en = '0;
				end
			endcase
		end
	end

	// ----------------------------------------
	// alignment check
	// ----------------------------------------
	always_comb begin
		misaligned = 1'b0;
		if (is_load) begin
			case (ex_bundle_i.func3)
				FUNC3_LOAD_HWORD, FUNC3_LOAD_UHWORD: misaligned = addr_lo[0];
				FUNC3_LOAD_WORD:                     misaligned = (addr_lo != 2'b00);
				default:                             misaligned = 1'b0;
			endcase
		end else if (is_store) begin
			case (ex_bundle_i.func3)
				FUNC3_STORE_HWORD: misaligned = addr_lo[0];
				FUNC3_STORE_WORD:  misaligned = (addr_lo != 2'b00);
				default:           misaligned = 1'b0;
			endcase
		end
	end

	// control bits
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			mem_bundle_o.valid      <= 1'b0;
			mem_bundle_o.byte_en    <= '0;
			mem_bundle_o.misaligned <= 1'b0;
		end else begin
			mem_bundle_o.valid      <= ex_bundle_i.valid;
			mem_bundle_o.byte_en    <= byte_en;
			mem_bundle_o.misaligned <= misaligned;
		end
	end

	// payload
	always_ff @(posedge clk_i) begin
		mem_bundle_o.encoding    <= ex_bundle_i.encoding;
		mem_bundle_o.func3       <= ex_bundle_i.func3;
		mem_bundle_o.fdest       <= ex_bundle_i.fdest;
		mem_bundle_o.result      <= ex_bundle_i.result;
		mem_bundle_o.lane_data   <= lane_data;
		mem_bundle_o.byte_offset <= addr_lo;
	end

endmodule

/* rtl/mem_stage_pkg.sv */
package mem_stage_pkg;

	// ----------------------------------------
	// basic widths
	// ----------------------------------------

	// data word and address
	typedef logic [31:0] word_t;

	// register file index
	typedef logic [4:0] reg_idx_t;

	// one enable per byte lane
	typedef logic [3:0] byte_en_t;

	// ----------------------------------------
	// stage bundles
	// ----------------------------------------

	// what execute hands over every cycle
	typedef struct packed {
		logic                     valid;
		rv32i_isa_pkg::encoding_t encoding;
		rv32i_isa_pkg::func3_t    func3;
		reg_idx_t                 fdest;
		// alu result, also the memory address
		word_t                    result;
		// rs2 value for stores
		word_t                    store_data;
	} exec_bundle_t;

	// latched request as seen by the data memory
	typedef struct packed {
		logic                     valid;
		rv32i_isa_pkg::encoding_t encoding;
		rv32i_isa_pkg::func3_t    func3;
		reg_idx_t                 fdest;
		word_t                    result;
		byte_en_t                 byte_en;
		// store data already replicated onto its lanes
		word_t                    lane_data;
		// addressed byte within the word
		logic [1:0]               byte_offset;
		logic                     misaligned;
	} mem_bundle_t;

	// result towards the register file
	typedef struct packed {
		logic     writeback_flag;
		reg_idx_t fdest;
		word_t    writeback_value;
		logic     exception;
	} wb_bundle_t;

endpackage

/* rtl/rv32i_isa_pkg.sv */
package rv32i_isa_pkg;

	// ----------------------------------------
	// instruction classes
	// ----------------------------------------

	// one-hot class from the decode stage
	typedef logic [8:0] encoding_t;

	// upper immediate forms
	localparam encoding_t ENCODING_LUI       = 9'b0_0000_0001;
	localparam encoding_t ENCODING_AUIPC     = 9'b0_0000_0010;

	// jumps write the link address
	localparam encoding_t ENCODING_JAL       = 9'b0_0000_0100;
	localparam encoding_t ENCODING_JALR      = 9'b0_0000_1000;

	// conditional branch has no destination
	localparam encoding_t ENCODING_BRANCH    = 9'b0_0001_0000;

	// memory access classes
	localparam encoding_t ENCODING_LOAD      = 9'b0_0010_0000;
	localparam encoding_t ENCODING_STORE     = 9'b0_0100_0000;

	// alu with immediate or register operand
	localparam encoding_t ENCODING_ARITH_IMM = 9'b0_1000_0000;
	localparam encoding_t ENCODING_ARITH_REG = 9'b1_0000_0000;

	// ----------------------------------------
	// func3 codes of the memory classes
	// ----------------------------------------

	typedef logic [2:0] func3_t;

	// loads, signed forms first
	localparam func3_t FUNC3_LOAD_BYTE   = 3'd0;
	localparam func3_t FUNC3_LOAD_HWORD  = 3'd1;
	localparam func3_t FUNC3_LOAD_WORD   = 3'd2;
	// zero extended forms
	localparam func3_t FUNC3_LOAD_UBYTE  = 3'd4;
	localparam func3_t FUNC3_LOAD_UHWORD = 3'd5;

	// stores, only the access size is encoded
	localparam func3_t FUNC3_STORE_BYTE  = 3'd0;
	localparam func3_t FUNC3_STORE_HWORD = 3'd1;
	localparam func3_t FUNC3_STORE_WORD  = 3'd2;

endpackage
